//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_dcache_subsystem
FILELIST  := filelist.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- design/dcache_pkg.sv
package dcache_pkg;

    localparam int n_ports     = 2;
    localparam int idx_w       = $clog2(n_ports);  // port index width
    localparam int addr_w      = 32;
    localparam int word_w      = 32;
    localparam int line_w      = 128;
    localparam int line_strb_w = line_w / 8;

    // port block FSM
    typedef enum logic [2:0] {
        st_idle,
        st_look_up,
        st_read_req,
        st_read_wait,
        st_write_req
    } cache_state_t;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_t;

    // bus transfer type
    typedef enum logic [2:0] {
        size_byte = 3'b000,
        size_half = 3'b001,
        size_word = 3'b010,
        size_line = 3'b100
    } access_size_t;

endpackage

//--- design/dcache_subsystem.sv
module dcache_subsystem (
    input  logic clk,
    input  logic rst,

    // cpu ports, one slice each
    input  logic [dcache_pkg::n_ports-1:0]                          valid,
    input  dcache_pkg::mem_op_t [dcache_pkg::n_ports-1:0]           op,
    input  logic [dcache_pkg::n_ports-1:0][dcache_pkg::addr_w-1:0]  pc,
    input  logic [dcache_pkg::n_ports-1:0]                          uncache,
    input  logic [dcache_pkg::n_ports-1:0][7:0]                     index,
    input  logic [dcache_pkg::n_ports-1:0][19:0]                    tag,
    input  logic [dcache_pkg::n_ports-1:0][3:0]                     offset,
    input  logic [dcache_pkg::n_ports-1:0][3:0]                     wstrb,
    input  logic [dcache_pkg::n_ports-1:0][dcache_pkg::word_w-1:0]  wdata,
    input  dcache_pkg::access_size_t [dcache_pkg::n_ports-1:0]      size,
    input  logic                                                    flush,
    input  logic [dcache_pkg::n_ports-1:0][dcache_pkg::addr_w-1:0]  flush_pc,
    output logic [dcache_pkg::n_ports-1:0]                          cache_ready,
    output logic [dcache_pkg::n_ports-1:0]                          cache_ack,
    output logic [dcache_pkg::n_ports-1:0]                          addr_ok,
    output logic [dcache_pkg::n_ports-1:0]                          data_ok,
    output logic [dcache_pkg::n_ports-1:0][dcache_pkg::word_w-1:0]  rdata,

    // memory bus
    output logic                               bus_rd_req,
    output dcache_pkg::access_size_t           bus_rd_type,
    output logic [dcache_pkg::addr_w-1:0]      bus_rd_addr,
    input  logic                               bus_rd_rdy,
    input  logic                               bus_ret_valid,
    input  logic                               bus_ret_last,
    input  logic [dcache_pkg::line_w-1:0]      bus_ret_data,
    output logic                               bus_wr_req,
    output dcache_pkg::access_size_t           bus_wr_type,
    output logic [dcache_pkg::addr_w-1:0]      bus_wr_addr,
    output logic [dcache_pkg::line_strb_w-1:0] bus_wr_wstrb,
    output logic [dcache_pkg::line_w-1:0]      bus_wr_data,
    input  logic                               bus_wr_rdy
);

    import dcache_pkg::*;

    // port block <-> arbiter
    logic [n_ports-1:0]                   rd_req;
    access_size_t [n_ports-1:0]           rd_type;
    logic [n_ports-1:0][addr_w-1:0]       rd_addr;
    logic [n_ports-1:0]                   rd_rdy;
    logic [n_ports-1:0]                   ret_valid;
    logic [n_ports-1:0][line_w-1:0]       ret_data;
    logic [n_ports-1:0]                   wr_req;
    access_size_t [n_ports-1:0]           wr_type;
    logic [n_ports-1:0][addr_w-1:0]       wr_addr;
    logic [n_ports-1:0][line_strb_w-1:0]  wr_wstrb;
    logic [n_ports-1:0][line_w-1:0]       wr_data;
    logic [n_ports-1:0]                   wr_rdy;

    for (genvar i = 0; i < n_ports; i++) begin : g_port
        uncached_dcache port_i (
            .clk        (clk),
            .rst        (rst),
            .valid      (valid[i]),
            .op         (op[i]),
            .pc         (pc[i]),
            .uncache    (uncache[i]),
            .index      (index[i]),
            .tag        (tag[i]),
            .offset     (offset[i]),
            .wstrb      (wstrb[i]),
            .wdata      (wdata[i]),
            .size       (size[i]),
            .flush      (flush),  // shared by all ports
            .flush_pc   (flush_pc[i]),
            .cache_ready(cache_ready[i]),
            .cache_ack  (cache_ack[i]),
            .addr_ok    (addr_ok[i]),
            .data_ok    (data_ok[i]),
            .rdata      (rdata[i]),
            .rd_req     (rd_req[i]),
            .rd_type    (rd_type[i]),
            .rd_addr    (rd_addr[i]),
            .rd_rdy     (rd_rdy[i]),
            .ret_valid  (ret_valid[i]),
            .ret_data   (ret_data[i]),
            .wr_req     (wr_req[i]),
            .wr_type    (wr_type[i]),
            .wr_addr    (wr_addr[i]),
            .wr_wstrb   (wr_wstrb[i]),
            .wr_data    (wr_data[i]),
            .wr_rdy     (wr_rdy[i])
        );
    end

    line_bus_arbiter arb_i (
        .clk          (clk),
        .rst          (rst),
        .rd_req       (rd_req),
        .rd_type      (rd_type),
        .rd_addr      (rd_addr),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_data     (ret_data),
        .wr_req       (wr_req),
        .wr_type      (wr_type),
        .wr_addr      (wr_addr),
        .wr_wstrb     (wr_wstrb),
        .wr_data      (wr_data),
        .wr_rdy       (wr_rdy),
        .bus_rd_req   (bus_rd_req),
        .bus_rd_type  (bus_rd_type),
        .bus_rd_addr  (bus_rd_addr),
        .bus_rd_rdy   (bus_rd_rdy),
        .bus_ret_valid(bus_ret_valid),
        .bus_ret_last (bus_ret_last),
        .bus_ret_data (bus_ret_data),
        .bus_wr_req   (bus_wr_req),
        .bus_wr_type  (bus_wr_type),
        .bus_wr_addr  (bus_wr_addr),
        .bus_wr_wstrb (bus_wr_wstrb),
        .bus_wr_data  (bus_wr_data),
        .bus_wr_rdy   (bus_wr_rdy)
    );

endmodule

//--- design/line_bus_arbiter.sv
module line_bus_arbiter (
    input  logic clk,
    input  logic rst,

    // port block side
    input  logic [dcache_pkg::n_ports-1:0]                          rd_req,
    input  dcache_pkg::access_size_t [dcache_pkg::n_ports-1:0]      rd_type,
    input  logic [dcache_pkg::n_ports-1:0][dcache_pkg::addr_w-1:0]  rd_addr,
    output logic [dcache_pkg::n_ports-1:0]                          rd_rdy,
    output logic [dcache_pkg::n_ports-1:0]                          ret_valid,
    output logic [dcache_pkg::n_ports-1:0][dcache_pkg::line_w-1:0]  ret_data,
    input  logic [dcache_pkg::n_ports-1:0]                          wr_req,
    input  dcache_pkg::access_size_t [dcache_pkg::n_ports-1:0]      wr_type,
    input  logic [dcache_pkg::n_ports-1:0][dcache_pkg::addr_w-1:0]  wr_addr,
    input  logic [dcache_pkg::n_ports-1:0][dcache_pkg::line_strb_w-1:0] wr_wstrb,
    input  logic [dcache_pkg::n_ports-1:0][dcache_pkg::line_w-1:0]  wr_data,
    output logic [dcache_pkg::n_ports-1:0]                          wr_rdy,

    // memory bus side
    output logic                                  bus_rd_req,
    output dcache_pkg::access_size_t              bus_rd_type,
    output logic [dcache_pkg::addr_w-1:0]         bus_rd_addr,
    input  logic                                  bus_rd_rdy,
    input  logic                                  bus_ret_valid,
    input  logic                                  bus_ret_last,
    input  logic [dcache_pkg::line_w-1:0]         bus_ret_data,
    output logic                                  bus_wr_req,
    output dcache_pkg::access_size_t              bus_wr_type,
    output logic [dcache_pkg::addr_w-1:0]         bus_wr_addr,
    output logic [dcache_pkg::line_strb_w-1:0]    bus_wr_wstrb,
    output logic [dcache_pkg::line_w-1:0]         bus_wr_data,
    input  logic                                  bus_wr_rdy
);

    import dcache_pkg::*;

    logic             rd_busy;
    logic [idx_w-1:0] rd_owner;
    logic [idx_w-1:0] rd_prio;
    logic [idx_w-1:0] rd_gnt;
    logic [idx_w-1:0] wr_prio;
    logic [idx_w-1:0] wr_gnt;

    // first requester at or after prio, wrapping around
    function automatic logic [idx_w-1:0] rr_pick(input logic [n_ports-1:0] req,
                                                 input logic [idx_w-1:0] prio);
        logic [idx_w-1:0] pick;
        logic             hit;
        int unsigned      cand;
        pick = prio;
        hit  = 1'b0;
        for (int k = 0; k < n_ports; k++) begin
            cand = (int'(prio) + k) % n_ports;
            if (!hit && req[cand]) begin
                pick = idx_w'(cand);
                hit  = 1'b1;
            end
        end
        return pick;
    endfunction

    function automatic logic [idx_w-1:0] next_idx(input logic [idx_w-1:0] idx);
        return (int'(idx) == n_ports - 1) ? '0 : idx + 1'b1;
    endfunction

    assign rd_gnt = rr_pick(rd_req, rd_prio);
    assign wr_gnt = rr_pick(wr_req, wr_prio);

    // read channel, locked to the owner until its line comes back
    assign bus_rd_req  = ~rd_busy & (|rd_req);
    assign bus_rd_type = rd_type[rd_gnt];
    assign bus_rd_addr = rd_addr[rd_gnt];

    // write channel
    assign bus_wr_req   = |wr_req;
    assign bus_wr_type  = wr_type[wr_gnt];
    assign bus_wr_addr  = wr_addr[wr_gnt];
    assign bus_wr_wstrb = wr_wstrb[wr_gnt];
    assign bus_wr_data  = wr_data[wr_gnt];

    always_comb begin
        rd_rdy    = '0;
        wr_rdy    = '0;
        ret_valid = '0;
        ret_data  = '0;
        if (bus_rd_req) rd_rdy[rd_gnt] = bus_rd_rdy;
        if (bus_wr_req) wr_rdy[wr_gnt] = bus_wr_rdy;
        if (rd_busy) begin
            ret_valid[rd_owner] = bus_ret_valid;
            ret_data[rd_owner]  = bus_ret_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy  <= 1'b0;
            rd_owner <= '0;
            rd_prio  <= '0;
            wr_prio  <= '0;
        end else begin
            if (bus_rd_req && bus_rd_rdy) begin
                rd_busy  <= 1'b1;
                rd_owner <= rd_gnt;
                rd_prio  <= next_idx(rd_gnt);
            end else if (rd_busy && bus_ret_valid) begin
                rd_busy <= 1'b0;  // single beat, channel free again
            end
            if (bus_wr_req && bus_wr_rdy) wr_prio <= next_idx(wr_gnt);
        end
    end

    a_rdy_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(rd_rdy) && $onehot0(wr_rdy));

    // every return answers an outstanding read, in one beat
    a_ret_owned: assert property (@(posedge clk) disable iff (rst)
        bus_ret_valid |-> rd_busy && bus_ret_last);

endmodule

//--- design/uncached_dcache.sv
module uncached_dcache (
    input  logic                       clk,
    input  logic                       rst,

    // cpu side
    input  logic                       valid,
    input  dcache_pkg::mem_op_t        op,
    input  logic [dcache_pkg::addr_w-1:0] pc,
    input  logic                       uncache,
    input  logic [7:0]                 index,
    input  logic [19:0]                tag,
    input  logic [3:0]                 offset,
    input  logic [3:0]                 wstrb,
    input  logic [dcache_pkg::word_w-1:0] wdata,
    input  dcache_pkg::access_size_t   size,
    input  logic                       flush,
    input  logic [dcache_pkg::addr_w-1:0] flush_pc,
    output logic                       cache_ready,
    output logic                       cache_ack,
    output logic                       addr_ok,
    output logic                       data_ok,
    output logic [dcache_pkg::word_w-1:0] rdata,

    // line bus side
    output logic                       rd_req,
    output dcache_pkg::access_size_t   rd_type,
    output logic [dcache_pkg::addr_w-1:0] rd_addr,
    input  logic                       rd_rdy,
    input  logic                       ret_valid,
    input  logic [dcache_pkg::line_w-1:0] ret_data,
    output logic                       wr_req,
    output dcache_pkg::access_size_t   wr_type,
    output logic [dcache_pkg::addr_w-1:0] wr_addr,
    output logic [dcache_pkg::line_strb_w-1:0] wr_wstrb,
    output logic [dcache_pkg::line_w-1:0] wr_data,
    input  logic                       wr_rdy
);

    import dcache_pkg::*;

    cache_state_t state, next_state;

    // request buffer
    logic              valid_buf;
    mem_op_t           op_buf;
    logic              uncache_buf;
    logic [addr_w-1:0] pc_buf;
    logic [addr_w-1:0] addr_buf;
    logic [3:0]        wstrb_buf;
    logic [word_w-1:0] wdata_buf;
    access_size_t      size_buf;

    logic       accept;
    logic       flush_hit;
    logic [1:0] lane;
    access_size_t bus_type;

    assign accept      = valid & cache_ready;
    assign cache_ready = (state == st_idle);
    assign cache_ack   = (state == st_idle) ? valid : 1'b0;
    assign lane        = addr_buf[3:2];  // word lane within the line

    // younger store gets squashed
    assign flush_hit = flush & (state == st_write_req) & (flush_pc <= pc_buf);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (valid) next_state = st_look_up;
            end
            st_look_up: begin
                if (!valid_buf) begin
                    next_state = st_idle;
                end else if (op_buf == op_write) begin
                    next_state = st_write_req;
                end else begin
                    next_state = st_read_req;
                end
            end
            st_read_req: begin
                if (rd_rdy) next_state = st_read_wait;  // address taken by bus
            end
            st_read_wait: begin
                if (ret_valid) next_state = st_idle;
            end
            st_write_req: begin
                if (flush_hit || wr_rdy) next_state = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            valid_buf <= 1'b0;
        end else begin
            state <= next_state;
            if (accept) begin
                valid_buf <= 1'b1;
            end else if (next_state == st_idle) begin
                valid_buf <= 1'b0;  // done or flushed
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_buf      <= op;
            uncache_buf <= uncache;
            pc_buf      <= pc;
            addr_buf    <= {tag, index, offset};
            wstrb_buf   <= wstrb;
            wdata_buf   <= wdata;
            size_buf    <= size;
        end
    end

    // cached accesses still ask for a whole line
    assign bus_type = uncache_buf ? size_buf : size_line;

    assign rd_req  = (state == st_read_req);
    assign rd_type = bus_type;
    assign rd_addr = addr_buf;

    assign wr_req   = (state == st_write_req) & ~flush_hit;
    assign wr_type  = bus_type;
    assign wr_addr  = addr_buf;  // left unaligned, lane comes from [3:2]
    assign wr_data  = line_w'(wdata_buf) << (lane * word_w);
    assign wr_wstrb = line_strb_w'(wstrb_buf) << (lane * 4);

    always_comb begin
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata   = '0;
        if (state == st_read_wait && ret_valid) begin
            addr_ok = 1'b1;
            data_ok = 1'b1;
            rdata   = ret_data[lane*word_w +: word_w];
        end else if (wr_req && wr_rdy) begin
            addr_ok = 1'b1;
            data_ok = 1'b1;
        end
    end

    // completion only from a bus phase, and the block is free right after
    a_data_ok_state: assert property (@(posedge clk) disable iff (rst)
        data_ok |-> (state inside {st_read_wait, st_write_req}) ##1 cache_ready);

    a_one_bus_req: assert property (@(posedge clk) disable iff (rst)
        !(rd_req && wr_req));

endmodule

//--- filelist.f
design/dcache_pkg.sv
design/uncached_dcache.sv
design/line_bus_arbiter.sv
design/dcache_subsystem.sv
tests/line_mem_model.sv
tests/tb_dcache_subsystem.sv

//--- tests/line_mem_model.sv
module line_mem_model (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               rd_req,
    input  logic [dcache_pkg::addr_w-1:0]      rd_addr,
    output logic                               rd_rdy,
    output logic                               ret_valid,
    output logic                               ret_last,
    output logic [dcache_pkg::line_w-1:0]      ret_data,
    input  logic                               wr_req,
    input  logic [dcache_pkg::addr_w-1:0]      wr_addr,
    input  logic [dcache_pkg::line_strb_w-1:0] wr_wstrb,
    input  logic [dcache_pkg::line_w-1:0]      wr_data,
    output logic                               wr_rdy
);
    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    logic [line_w-1:0] mem [256];
    logic              pending;   // one read in flight at most
    logic [7:0]        rd_line;
    logic [1:0]        wait_cnt;
    integer            seed = 33843;

    initial begin
        for (int l = 0; l < 256; l++) begin
            for (int w = 0; w < 4; w++) begin
                mem[l][w*32 +: 32] = 32'((l * 4 + w + 1) * 32'h9e37_79b1);  // distinct per word
            end
        end
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        pending   = 1'b0;
        rd_line   = '0;
        wait_cnt  = '0;
    end

    // bus handshakes are taken on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            pending  <= 1'b0;
            wait_cnt <= '0;
        end else begin
            if (wr_req && wr_rdy) begin
                for (int b = 0; b < line_strb_w; b++) begin
                    if (wr_wstrb[b]) mem[wr_addr[11:4]][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
            if (rd_req && rd_rdy) begin
                pending  <= 1'b1;
                rd_line  <= rd_addr[11:4];
                wait_cnt <= 2'($random(seed));  // 1 to 4 cycles until the return
            end else if (ret_valid) begin
                pending <= 1'b0;
            end else if (pending && wait_cnt != 0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    // responses change on the falling edge only
    always @(negedge clk) begin
        rd_rdy    <= !rst && (2'($random(seed)) != 2'd0);
        wr_rdy    <= !rst && (2'($random(seed)) != 2'd0);
        ret_valid <= !rst && pending && (wait_cnt == 0);
        ret_last  <= !rst && pending && (wait_cnt == 0);  // single beat
        ret_data  <= mem[rd_line];
    end

endmodule

//--- tests/tb_dcache_subsystem.sv
module tb_dcache_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    localparam int n_directed = 7;   // per port
    localparam int n_rand_ops = 40;  // per port, all ports at once
    localparam int n_ops      = n_ports * (n_directed + n_rand_ops);
    localparam int port_bit   = 11;  // index msb picks the port's half of memory

    logic clk;
    logic rst;

    logic [n_ports-1:0]                   valid;
    mem_op_t [n_ports-1:0]                op;
    logic [n_ports-1:0][addr_w-1:0]       pc;
    logic [n_ports-1:0]                   uncache;
    logic [n_ports-1:0][7:0]              index;
    logic [n_ports-1:0][19:0]             tag;
    logic [n_ports-1:0][3:0]              offset;
    logic [n_ports-1:0][3:0]              wstrb;
    logic [n_ports-1:0][word_w-1:0]       wdata;
    access_size_t [n_ports-1:0]           size;
    logic                                 flush;
    logic [n_ports-1:0][addr_w-1:0]       flush_pc;
    logic [n_ports-1:0]                   cache_ready;
    logic [n_ports-1:0]                   cache_ack;
    logic [n_ports-1:0]                   addr_ok;
    logic [n_ports-1:0]                   data_ok;
    logic [n_ports-1:0][word_w-1:0]       rdata;

    logic                   bus_rd_req;
    access_size_t           bus_rd_type;
    logic [addr_w-1:0]      bus_rd_addr;
    logic                   bus_rd_rdy;
    logic                   bus_ret_valid;
    logic                   bus_ret_last;
    logic [line_w-1:0]      bus_ret_data;
    logic                   bus_wr_req;
    access_size_t           bus_wr_type;
    logic [addr_w-1:0]      bus_wr_addr;
    logic [line_strb_w-1:0] bus_wr_wstrb;
    logic [line_w-1:0]      bus_wr_data;
    logic                   bus_wr_rdy;

    // what each port's current request should look like
    access_size_t           exp_type  [n_ports];
    logic [addr_w-1:0]      exp_addr  [n_ports];
    logic [line_strb_w-1:0] exp_wstrb [n_ports];
    logic [line_w-1:0]      exp_wdata [n_ports];
    logic [word_w-1:0]      exp_rdata [n_ports];
    logic [n_ports-1:0]     pend_read;
    logic [n_ports-1:0]     pend_write;
    logic [word_w-1:0]      shadow [1024];  // one entry per 32-bit word
    int                     flush_port;
    int                     err_count;

    dcache_subsystem dut_i (.*);

    line_mem_model mem_i (
        .clk      (clk),
        .rst      (rst),
        .rd_req   (bus_rd_req),
        .rd_addr  (bus_rd_addr),
        .rd_rdy   (bus_rd_rdy),
        .ret_valid(bus_ret_valid),
        .ret_last (bus_ret_last),
        .ret_data (bus_ret_data),
        .wr_req   (bus_wr_req),
        .wr_addr  (bus_wr_addr),
        .wr_wstrb (bus_wr_wstrb),
        .wr_data  (bus_wr_data),
        .wr_rdy   (bus_wr_rdy)
    );

    task automatic abort_run(input string why);
        err_count++;
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        abort_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual));
    endtask

    for (genvar g = 0; g < n_ports; g++) begin : g_port_chk
        a_rdata: assert property (@(posedge clk) disable iff (rst)
            data_ok[g] && pend_read[g] |-> rdata[g] == exp_rdata[g])
            else report_mismatch($sformatf("rdata[%0d]", g), 128'(exp_rdata[g]),
                                 128'($sampled(rdata[g])));
        a_done_owned: assert property (@(posedge clk) disable iff (rst)
            data_ok[g] |-> pend_read[g] || pend_write[g])
            else abort_run($sformatf("port %0d gave data_ok with nothing pending", g));
        a_addr_ok: assert property (@(posedge clk) disable iff (rst)
            addr_ok[g] == data_ok[g])
            else report_mismatch($sformatf("addr_ok[%0d]", g), 128'($sampled(data_ok[g])),
                                 128'($sampled(addr_ok[g])));
        a_ack: assert property (@(posedge clk) disable iff (rst)
            cache_ready[g] |-> cache_ack[g] == valid[g])
            else report_mismatch($sformatf("cache_ack[%0d]", g), 128'($sampled(valid[g])),
                                 128'($sampled(cache_ack[g])));
    end

    a_rd_owned: assert property (@(posedge clk) disable iff (rst)
        bus_rd_req && bus_rd_rdy |-> pend_read[bus_rd_addr[port_bit]])
        else abort_run("bus read issued with no load pending");
    a_rd_type: assert property (@(posedge clk) disable iff (rst)
        bus_rd_req && bus_rd_rdy |-> bus_rd_type == exp_type[bus_rd_addr[port_bit]])
        else report_mismatch("bus_rd_type", 128'(exp_type[$sampled(bus_rd_addr[port_bit])]),
                             128'($sampled(bus_rd_type)));
    a_rd_addr: assert property (@(posedge clk) disable iff (rst)
        bus_rd_req && bus_rd_rdy |-> bus_rd_addr == exp_addr[bus_rd_addr[port_bit]])
        else report_mismatch("bus_rd_addr", 128'(exp_addr[$sampled(bus_rd_addr[port_bit])]),
                             128'($sampled(bus_rd_addr)));
    a_wr_owned: assert property (@(posedge clk) disable iff (rst)
        bus_wr_req && bus_wr_rdy |-> pend_write[bus_wr_addr[port_bit]])
        else abort_run("bus write issued with no store pending");
    a_wr_type: assert property (@(posedge clk) disable iff (rst)
        bus_wr_req && bus_wr_rdy |-> bus_wr_type == exp_type[bus_wr_addr[port_bit]])
        else report_mismatch("bus_wr_type", 128'(exp_type[$sampled(bus_wr_addr[port_bit])]),
                             128'($sampled(bus_wr_type)));
    a_wr_addr: assert property (@(posedge clk) disable iff (rst)
        bus_wr_req && bus_wr_rdy |-> bus_wr_addr == exp_addr[bus_wr_addr[port_bit]])
        else report_mismatch("bus_wr_addr", 128'(exp_addr[$sampled(bus_wr_addr[port_bit])]),
                             128'($sampled(bus_wr_addr)));
    a_wr_strb: assert property (@(posedge clk) disable iff (rst)
        bus_wr_req && bus_wr_rdy |-> bus_wr_wstrb == exp_wstrb[bus_wr_addr[port_bit]])
        else report_mismatch("bus_wr_wstrb", 128'(exp_wstrb[$sampled(bus_wr_addr[port_bit])]),
                             128'($sampled(bus_wr_wstrb)));
    a_wr_data: assert property (@(posedge clk) disable iff (rst)
        bus_wr_req && bus_wr_rdy |-> bus_wr_data == exp_wdata[bus_wr_addr[port_bit]])
        else report_mismatch("bus_wr_data", exp_wdata[$sampled(bus_wr_addr[port_bit])],
                             $sampled(bus_wr_data));
    a_flush: assert property (@(posedge clk) disable iff (rst)
        flush |-> !data_ok[flush_port] && !bus_wr_req ##1 cache_ready[flush_port])
        else abort_run("flushed store was not cancelled cleanly");
    a_rdy_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(dut_i.arb_i.rd_rdy) && $onehot0(dut_i.arb_i.wr_rdy))
        else abort_run("arbiter gave ready to more than one port");

    // one request on port p, optionally squashed by a flush while the store waits
    task automatic do_access(input int p, input mem_op_t kind, input logic unc,
                             input logic [7:0] idx, input logic [3:0] off,
                             input logic [3:0] strb, input logic [31:0] data,
                             input access_size_t sz, input logic cancel);
        logic [9:0] w;
        w = {idx, off[3:2]};
        @(negedge clk);
        valid[p]      = 1'b1;
        op[p]         = kind;
        pc[p]         = 32'h0000_4000 + 32'({idx, off});
        uncache[p]    = unc;
        index[p]      = idx;
        tag[p]        = {4'(p), 8'h3c, idx};
        offset[p]     = off;
        wstrb[p]      = strb;
        wdata[p]      = data;
        size[p]       = sz;
        exp_type[p]   = unc ? sz : size_line;
        exp_addr[p]   = {tag[p], idx, off};
        exp_wstrb[p]  = line_strb_w'(strb) << (off[3:2] * 4);
        exp_wdata[p]  = line_w'(data) << (off[3:2] * 32);
        exp_rdata[p]  = shadow[w];
        pend_read[p]  = (kind == op_read);
        pend_write[p] = (kind == op_write);
        do @(posedge clk); while (!cache_ready[p]);  // accepted on this edge
        @(negedge clk);
        valid[p] = 1'b0;
        if (cancel) begin
            @(negedge clk);  // first write request cycle
            flush_port  = p;
            flush_pc[p] = pc[p] - 32'(4 * p);  // equal on port 0, below on port 1
            flush       = 1'b1;
            @(negedge clk);
            flush         = 1'b0;
            flush_pc[p]   = '1;
            pend_write[p] = 1'b0;
        end else begin
            do @(posedge clk); while (!data_ok[p]);
            pend_read[p]  = 1'b0;
            pend_write[p] = 1'b0;
            if (kind == op_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) shadow[w][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
    endtask

    task automatic directed_port(input int p);
        logic [7:0] idx;
        idx = {1'(p), 7'h2a};
        do_access(p, op_write, 1'b1, idx, 4'h4, 4'hf, 32'h1122_3344, size_word, 1'b0);
        do_access(p, op_write, 1'b0, idx, 4'h4, 4'b0101, 32'haabb_ccdd, size_word, 1'b0);
        do_access(p, op_read, 1'b0, idx, 4'h4, 4'h0, 32'h0, size_word, 1'b0);
        do_access(p, op_write, 1'b1, idx, 4'he, 4'b1100, 32'h5566_7788, size_half, 1'b0);
        do_access(p, op_read, 1'b1, idx, 4'he, 4'h0, 32'h0, size_half, 1'b0);
        do_access(p, op_write, 1'b0, idx, 4'h8, 4'hf, 32'hdead_beef, size_word, 1'b1);
        do_access(p, op_read, 1'b1, idx, 4'h8, 4'h0, 32'h0, size_word, 1'b0);  // still old
    endtask

    task automatic random_port(input int p);
        integer       seed;
        logic [31:0]  r;
        mem_op_t      kind;
        access_size_t sz;
        seed = 33843;
        repeat (p) r = $random(seed);  // shift the stream per port
        for (int i = 0; i < n_rand_ops; i++) begin
            r    = $random(seed);
            kind = r[0] ? op_write : op_read;
            case (r[2:1])
                2'd0:    sz = size_byte;
                2'd1:    sz = size_half;
                default: sz = size_word;
            endcase
            do_access(p, kind, r[3], {1'(p), 4'h0, r[6:4]}, r[10:7], r[14:11],
                      $random(seed), sz, 1'b0);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (n_ops * 40) @(posedge clk);
        abort_run("timeout, requests stopped completing");
    end

    initial begin
        rst        = 1'b1;
        valid      = '0;
        pc         = '0;
        uncache    = '0;
        index      = '0;
        tag        = '0;
        offset     = '0;
        wstrb      = '0;
        wdata      = '0;
        flush      = 1'b0;
        flush_port = 0;
        err_count  = 0;
        pend_read  = '0;
        pend_write = '0;
        for (int p = 0; p < n_ports; p++) begin
            op[p]        = op_read;
            size[p]      = size_word;
            flush_pc[p]  = '1;  // no store is ever younger than this
            exp_type[p]  = size_line;
            exp_addr[p]  = '0;
            exp_wstrb[p] = '0;
            exp_wdata[p] = '0;
            exp_rdata[p] = '0;
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        for (int l = 0; l < 256; l++) begin
            for (int w = 0; w < 4; w++) begin
                shadow[l * 4 + w] = mem_i.mem[l][w*32 +: 32];
            end
        end
        for (int p = 0; p < n_ports; p++) begin
            directed_port(p);
        end
        for (int p = 0; p < n_ports; p++) begin
            fork
                automatic int q = p;
                random_port(q);
            join_none
        end
        wait fork;
        repeat (2) @(posedge clk);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
